// File: hw/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

	//////////////////////////////////////////////////
	// instruction word layout
	//////////////////////////////////////////////////

	localparam int INST_W = 18;
	localparam int OPC_W = 4;
	localparam int IMM_W = 8;
	localparam int ALU_OP_W = 3;

	// field positions, msb then lsb
	localparam int OPC_MSB = 17;
	localparam int OPC_LSB = 14;
	localparam int DST_MSB = 13;
	localparam int DST_LSB = 10;
	localparam int SRC_MSB = 9;
	localparam int SRC_LSB = 6;
	// immediate shares the top of the source field
	localparam int IMM_MSB = 9;
	localparam int IMM_LSB = 2;

	typedef logic [INST_W-1:0] instWord_t;
	typedef logic [IMM_W-1:0] immField_t;

	// one code per opcode, all sixteen in use
	typedef enum logic [OPC_W-1:0] {
		OP_NOP  = 4'h0,
		OP_ADD  = 4'h1,
		OP_ADDC = 4'h2,
		OP_SUB  = 4'h3,
		OP_AND  = 4'h4,
		OP_OR   = 4'h5,
		OP_XOR  = 4'h6,
		OP_CMP  = 4'h7,
		OP_MOV  = 4'h8,
		OP_LSH  = 4'h9,
		OP_ADDI = 4'hA,
		OP_SUBI = 4'hB,
		OP_CMPI = 4'hC,
		OP_MOVI = 4'hD,
		OP_LOAD = 4'hE,
		OP_STOR = 4'hF
	} opcode_t;

	//////////////////////////////////////////////////
	// alu operations and flag positions
	//////////////////////////////////////////////////

	typedef enum logic [ALU_OP_W-1:0] {
		ALU_ADD   = 3'd0,
		ALU_ADDC  = 3'd1,
		ALU_SUB   = 3'd2,
		ALU_AND   = 3'd3,
		ALU_OR    = 3'd4,
		ALU_XOR   = 3'd5,
		// b straight through, used by moves and stores
		ALU_PASSB = 3'd6,
		ALU_SHL   = 3'd7
	} aluOp_t;

	// carry/borrow, unsigned less, overflow, zero, negative
	localparam int FLAG_C = 4;
	localparam int FLAG_L = 3;
	localparam int FLAG_F = 2;
	localparam int FLAG_Z = 1;
	localparam int FLAG_N = 0;

endpackage

`default_nettype wire

// File: hw/cpuDataPkg.sv
`default_nettype none

package cpuDataPkg;

	//////////////////////////////////////////////////
	// data path widths
	//////////////////////////////////////////////////

	localparam int WORD_W = 16;
	localparam int NUM_REGS = 16;
	localparam int REG_IDX_W = $clog2(NUM_REGS);
	localparam int FLAG_W = 5;
	// memory words are wider than registers, upper bits dropped on load
	localparam int MEM_DATA_W = 18;
	// shift amount taken from the low bits of b
	localparam int SHIFT_W = $clog2(WORD_W);

	// one register or memory word
	typedef logic [WORD_W-1:0] word_t;

	// register number, r0 to r15
	typedef logic [REG_IDX_W-1:0] regIdx_t;

	// C L F Z N, msb first
	typedef logic [FLAG_W-1:0] flags_t;

endpackage

`default_nettype wire

// File: hw/regPortIf.sv
`timescale 1ns/1ps
`default_nettype none

interface regPortIf import cpuDataPkg::*; ();

	// read selects from the decoder
	regIdx_t readA;
	regIdx_t readB;
	// write target and the decoder's request to write it
	regIdx_t loadReg;
	logic loadReq;
	// request after reset masking, sampled at the CLK edge
	logic loadEn;
	// write-back word from the result select
	word_t writeData;
	// read port outputs
	word_t dataA;
	word_t dataB;

	// instruction decoder side
	modport decode (output readA, readB, loadReg, loadReq);

	// register bank side
	modport bank (input readA, readB, loadReg, loadEn, writeData, output dataA, dataB);

	// result select and write gating in the core
	modport result (input dataA, dataB, loadReq, output writeData, loadEn);

endinterface

`default_nettype wire

// File: hw/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instDecoder import cpuIsaPkg::*, cpuDataPkg::*; (
	input instWord_t inst,
	regPortIf.decode regs,
	output aluOp_t aluOp,
	output word_t imm,
	output logic selectImm,
	output logic selectMem,
	output logic setArith,
	output logic setCmp,
	output logic memWrite,
	output logic memEn
);

	opcode_t opc;
	regIdx_t rDst;
	regIdx_t rSrc;
	immField_t immField;
	// alu op then eight control bits
	logic [ALU_OP_W+7:0] ctl;
	logic [ALU_OP_W-1:0] aluBits;
	// memory ops address through rSrc and take data from rDst
	logic addrSrc;

	// field split
	assign opc = opcode_t'(inst[OPC_MSB:OPC_LSB]);
	assign rDst = inst[DST_MSB:DST_LSB];
	assign rSrc = inst[SRC_MSB:SRC_LSB];
	assign immField = inst[IMM_MSB:IMM_LSB];

	// MOVI zero-extends, the other immediate ops sign-extend
	assign imm = (opc == OP_MOVI) ? {{(WORD_W-IMM_W){1'b0}}, immField}
		: {{(WORD_W-IMM_W){immField[IMM_W-1]}}, immField};

	//////////////////////////////////////////////////
	// decode table
	//////////////////////////////////////////////////

	always_comb begin
		// bits: imm mem arith cmp load memWr memEn addrSrc
		case (opc)
			OP_NOP:  ctl = {ALU_PASSB, 8'b0_0_0_0_0_0_0_0};
			OP_ADD:  ctl = {ALU_ADD,   8'b0_0_1_0_1_0_0_0};
			OP_ADDC: ctl = {ALU_ADDC,  8'b0_0_1_0_1_0_0_0};
			OP_SUB:  ctl = {ALU_SUB,   8'b0_0_1_0_1_0_0_0};
			OP_AND:  ctl = {ALU_AND,   8'b0_0_0_0_1_0_0_0};
			OP_OR:   ctl = {ALU_OR,    8'b0_0_0_0_1_0_0_0};
			OP_XOR:  ctl = {ALU_XOR,   8'b0_0_0_0_1_0_0_0};
			// compare is a subtract with no write-back
			OP_CMP:  ctl = {ALU_SUB,   8'b0_0_0_1_0_0_0_0};
			OP_MOV:  ctl = {ALU_PASSB, 8'b0_0_0_0_1_0_0_0};
			OP_LSH:  ctl = {ALU_SHL,   8'b0_0_0_0_1_0_0_0};
			OP_ADDI: ctl = {ALU_ADD,   8'b1_0_1_0_1_0_0_0};
			OP_SUBI: ctl = {ALU_SUB,   8'b1_0_1_0_1_0_0_0};
			OP_CMPI: ctl = {ALU_SUB,   8'b1_0_0_1_0_0_0_0};
			OP_MOVI: ctl = {ALU_PASSB, 8'b1_0_0_0_1_0_0_0};
			// load writes rDst from memory read data
			OP_LOAD: ctl = {ALU_PASSB, 8'b0_1_0_0_1_0_1_1};
			// store data is rDst through PASSB
			OP_STOR: ctl = {ALU_PASSB, 8'b0_0_0_0_0_1_1_1};
			default: ctl = {ALU_PASSB, 8'b0_0_0_0_0_0_0_0};
		endcase

		{aluBits, selectImm, selectMem, setArith, setCmp} = ctl[ALU_OP_W+7:4];
		{regs.loadReq, memWrite, memEn, addrSrc} = ctl[3:0];
		aluOp = aluOp_t'(aluBits);

		// A is the address for memory ops, rDst otherwise
		regs.readA = addrSrc ? rSrc : rDst;
		regs.readB = addrSrc ? rDst : rSrc;
		regs.loadReg = rDst;

		// a store also enables the memory
		assert (!memWrite || memEn)
			else $error("instDecoder: memWrite without memEn, opcode %h", opc);
	end

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuDataPkg::*; (
	input logic CLK,
	input logic rst,
	regPortIf.bank regs
);

	// one write enable per register
	logic [NUM_REGS-1:0] wrEn;
	// register contents for the read muxes
	word_t regOut [NUM_REGS];

	//////////////////////////////////////////////////
	// register bank
	//////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_REGS; i++) begin : genReg
		word_t q;

		// address decode for this slot
		assign wrEn[i] = regs.loadEn && (regs.loadReg == regIdx_t'(i));

		// whole bank clears together
		always_ff @(posedge CLK) begin
			if (rst) begin
				q <= '0;
			end else if (wrEn[i]) begin
				q <= regs.writeData;
			end
		end

		assign regOut[i] = q;
	end

	//////////////////////////////////////////////////
	// read ports
	//////////////////////////////////////////////////

	// port A, also the memory address
	assign regs.dataA = regOut[regs.readA];

	// port B, before the immediate select
	assign regs.dataB = regOut[regs.readB];

	// write decode is one-hot or idle
	assert property (@(posedge CLK) disable iff (rst) $onehot0(wrEn))
		else $error("regFile: several write enables, mask %h", wrEn);

	// core masks write requests while reset is held
	assert property (@(posedge CLK) rst |-> !regs.loadEn)
		else $error("regFile: loadEn high during reset");

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import cpuIsaPkg::*, cpuDataPkg::*; (
	input logic CLK,
	input logic rst,
	input word_t a,
	input word_t b,
	input aluOp_t op,
	input logic setArith,
	input logic setCmp,
	output word_t y,
	output flags_t flags
);

	flags_t flagNext;
	// one extra bit for carry out or borrow
	logic [WORD_W:0] sum;
	logic [WORD_W:0] diff;
	logic carryIn;
	logic addOvf;
	logic subOvf;

	//////////////////////////////////////////////////
	// adder and subtractor
	//////////////////////////////////////////////////

	// ADDC feeds back the stored carry
	assign carryIn = (op == ALU_ADDC) ? flags[FLAG_C] : 1'b0;

	assign sum = {1'b0, a} + {1'b0, b} + {{WORD_W{1'b0}}, carryIn};

	// msb of diff is the borrow
	assign diff = {1'b0, a} - {1'b0, b};

	// signed overflow, same sign in and different sign out
	assign addOvf = (a[WORD_W-1] == b[WORD_W-1]) && (sum[WORD_W-1] != a[WORD_W-1]);
	// subtract overflow needs opposite signs in
	assign subOvf = (a[WORD_W-1] != b[WORD_W-1]) && (diff[WORD_W-1] != a[WORD_W-1]);

	// result mux
	always_comb begin
		case (op)
			ALU_ADD,
			ALU_ADDC: y = sum[WORD_W-1:0];
			ALU_SUB: y = diff[WORD_W-1:0];
			ALU_AND: y = a & b;
			ALU_OR: y = a | b;
			ALU_XOR: y = a ^ b;
			// shift count from low bits of b
			ALU_SHL: y = a << b[SHIFT_W-1:0];
			default: y = b;
		endcase
	end

	//////////////////////////////////////////////////
	// flag register
	//////////////////////////////////////////////////

	always_comb begin
		// hold unless an arithmetic or compare op
		flagNext = flags;
		if (setArith) begin
			if (op == ALU_SUB) begin
				flagNext[FLAG_C] = diff[WORD_W];
				flagNext[FLAG_F] = subOvf;
			end else begin
				flagNext[FLAG_C] = sum[WORD_W];
				flagNext[FLAG_F] = addOvf;
			end
			flagNext[FLAG_Z] = (y == '0);
			flagNext[FLAG_N] = y[WORD_W-1];
		end else if (setCmp) begin
			// compare reports relations, not the difference
			flagNext[FLAG_L] = (a < b);
			flagNext[FLAG_Z] = (a == b);
			flagNext[FLAG_N] = ($signed(a) < $signed(b));
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			flags <= '0;
		end else begin
			flags <= flagNext;
		end
	end

	// decoder asks for one flag rule at a time
	assert property (@(posedge CLK) disable iff (rst) !(setArith && setCmp))
		else $error("alu: setArith and setCmp both high, op %s", op.name());

endmodule

`default_nettype wire

// File: hw/datapathCore.sv
`timescale 1ns/1ps
`default_nettype none

module datapathCore import cpuIsaPkg::*, cpuDataPkg::*; (
	input logic CLK,
	input logic rst,
	input instWord_t inst,
	input logic [MEM_DATA_W-1:0] memRdata,
	output logic memWrite,
	output logic memEn,
	output word_t memAddr,
	output word_t memWdata,
	output flags_t flags,
	output word_t debugB,
	output word_t aluOut
);

	// register file select, write and read bundle
	regPortIf regs ();

	aluOp_t aluOp;
	word_t imm;
	logic selectImm;
	logic selectMem;
	logic setArith;
	logic setCmp;

	//////////////////////////////////////////////////
	// decode, register file, alu
	//////////////////////////////////////////////////

	instDecoder decoder (
		.inst(inst),
		.regs(regs.decode),
		.aluOp(aluOp),
		.imm(imm),
		.selectImm(selectImm),
		.selectMem(selectMem),
		.setArith(setArith),
		.setCmp(setCmp),
		.memWrite(memWrite),
		.memEn(memEn)
	);

	regFile bank (
		.CLK(CLK),
		.rst(rst),
		.regs(regs.bank)
	);

	// B operand is the selected register or immediate
	alu aluUnit (
		.CLK(CLK),
		.rst(rst),
		.a(regs.dataA),
		.b(debugB),
		.op(aluOp),
		.setArith(setArith),
		.setCmp(setCmp),
		.y(aluOut),
		.flags(flags)
	);

	// operand B select
	always_comb begin
		debugB = selectImm ? imm : regs.dataB;
	end

	// write-back select, low memory bits for loads
	always_comb begin
		regs.writeData = selectMem ? memRdata[WORD_W-1:0] : aluOut;
	end

	// store data and address
	assign memWdata = regs.writeData;
	assign memAddr = regs.dataA;

	// no register writes while in reset
	assign regs.loadEn = regs.loadReq && !rst;

endmodule

`default_nettype wire

// File: testbench/tbChecker.sv
`timescale 1ns/1ps
`default_nettype none

module tbChecker import cpuIsaPkg::*, cpuDataPkg::*; (
	input logic CLK,
	input logic rst,
	input instWord_t inst,
	input logic memWrite,
	input logic memEn,
	input word_t memAddr,
	input word_t memWdata,
	input flags_t flags,
	input word_t debugB,
	input word_t aluOut,
	output int errors
);

	localparam int MEM_WORDS = 256;

	// expected outputs and state change of one instruction
	typedef struct packed {
		word_t addr;
		word_t wdata;
		logic write;
		logic en;
		word_t y;
		word_t b;
		logic doWrite;
		regIdx_t dst;
		flags_t flagsNext;
	} prediction_t;

	// shadow state of the datapath and of the memory
	word_t shadowReg [NUM_REGS];
	flags_t shadowFlags;
	logic [MEM_DATA_W-1:0] shadowMem [MEM_WORDS];
	prediction_t pred;

	//////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////

	function automatic prediction_t predict(instWord_t i);
		prediction_t p;
		opcode_t op;
		regIdx_t d;
		word_t a;
		logic carry;
		logic arith;
		int usum;
		int sres;

		op = opcode_t'(i[17:14]);
		d = i[13:10];
		p = '0;
		p.dst = d;
		p.flagsNext = shadowFlags;
		// A is rDst, B is rSrc unless the opcode says otherwise
		a = shadowReg[d];
		p.b = shadowReg[i[9:6]];
		if (op inside {OP_ADDI, OP_SUBI, OP_CMPI}) begin
			p.b = {{8{i[9]}}, i[9:2]};
		end else if (op == OP_MOVI) begin
			p.b = {8'h00, i[9:2]};
		end else if (op inside {OP_LOAD, OP_STOR}) begin
			// rSrc gives the address and rDst passes through as B
			a = shadowReg[i[9:6]];
			p.b = shadowReg[d];
		end
		carry = (op == OP_ADDC) ? shadowFlags[FLAG_C] : 1'b0;
		arith = op inside {OP_ADD, OP_ADDC, OP_ADDI, OP_SUB, OP_SUBI};
		case (op)
			OP_ADD, OP_ADDC, OP_ADDI: begin
				// unsigned sum above 16 bits is the carry
				usum = int'(a) + int'(p.b) + int'(carry);
				sres = int'($signed(a)) + int'($signed(p.b)) + int'(carry);
				p.y = word_t'(usum);
				p.flagsNext[FLAG_C] = usum > 65535;
				p.flagsNext[FLAG_F] = (sres > 32767) || (sres < -32768);
			end
			OP_SUB, OP_SUBI, OP_CMP, OP_CMPI: begin
				p.y = a - p.b;
				sres = int'($signed(a)) - int'($signed(p.b));
				if (arith) begin
					// C is the borrow here
					p.flagsNext[FLAG_C] = a < p.b;
					p.flagsNext[FLAG_F] = (sres > 32767) || (sres < -32768);
				end else begin
					p.flagsNext[FLAG_L] = a < p.b;
					p.flagsNext[FLAG_Z] = a == p.b;
					p.flagsNext[FLAG_N] = sres < 0;
				end
			end
			OP_AND: p.y = a & p.b;
			OP_OR: p.y = a | p.b;
			OP_XOR: p.y = a ^ p.b;
			OP_LSH: p.y = a << p.b[3:0];
			default: p.y = p.b;
		endcase
		if (arith) begin
			p.flagsNext[FLAG_Z] = p.y == '0;
			p.flagsNext[FLAG_N] = p.y[WORD_W-1];
		end
		p.addr = a;
		p.write = op == OP_STOR;
		p.en = op inside {OP_LOAD, OP_STOR};
		// write-back word with the upper memory bits dropped
		p.wdata = (op == OP_LOAD) ? shadowMem[a[7:0]][WORD_W-1:0] : p.y;
		p.doWrite = !(op inside {OP_NOP, OP_CMP, OP_CMPI, OP_STOR});
		return p;
	endfunction

	task automatic checkValue(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			errors++;
			$display("Mismatch %s at %0t: expected %h, got %h", name, $time, expected, actual);
		end
	endtask

	//////////////////////////////////////////////////
	// compare process
	//////////////////////////////////////////////////

	initial begin
		errors = 0;
		shadowFlags = '0;
		// fill matches the memory model in tbDatapath
		for (int w = 0; w < MEM_WORDS; w++) begin
			shadowMem[w] = {w[1:0], ~w[7:0], w[7:0]};
		end
		forever begin
			// just before the rising edge
			@(negedge CLK);
			#18;
			pred = predict(inst);
			if (!rst) begin
				checkValue("memAddr", pred.addr, memAddr);
				checkValue("memWdata", pred.wdata, memWdata);
				checkValue("memWrite", word_t'(pred.write), word_t'(memWrite));
				checkValue("memEn", word_t'(pred.en), word_t'(memEn));
				checkValue("aluOut", pred.y, aluOut);
				checkValue("debugB", pred.b, debugB);
			end
			@(posedge CLK);
			#1;
			if (rst) begin
				foreach (shadowReg[r]) begin
					shadowReg[r] = '0;
				end
				shadowFlags = '0;
			end else begin
				if (pred.doWrite) begin
					shadowReg[pred.dst] = pred.wdata;
				end
				if (pred.write) begin
					shadowMem[pred.addr[7:0]] = {2'b11, pred.y};
				end
				shadowFlags = pred.flagsNext;
				// flags settle after the edge
				checkValue("flags", word_t'(shadowFlags), word_t'(flags));
			end
		end
	end

endmodule

`default_nettype wire

// File: testbench/tbDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module tbDatapath import cpuIsaPkg::*, cpuDataPkg::*; ();

	localparam int HALF_PERIOD = 20;
	localparam int MEM_WORDS = 256;
	// all tests together run about 330 cycles
	localparam int TEST_CYCLES = 330;
	localparam int MAX_CYCLES = 3 * TEST_CYCLES + 10;

	logic CLK;
	logic rst;
	instWord_t inst;
	logic [MEM_DATA_W-1:0] memRdata;
	logic memWrite;
	logic memEn;
	word_t memAddr;
	word_t memWdata;
	flags_t flags;
	word_t debugB;
	word_t aluOut;
	int errors;

	// memory model, 18-bit words
	logic [MEM_DATA_W-1:0] mem [MEM_WORDS];
	logic [15:0] lfsr;
	int cycles = 0;
	int testsRun = 0;
	int testsFailed = 0;
	int errorsBefore = 0;

	datapathCore DUT (
		.CLK(CLK),
		.rst(rst),
		.inst(inst),
		.memRdata(memRdata),
		.memWrite(memWrite),
		.memEn(memEn),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.flags(flags),
		.debugB(debugB),
		.aluOut(aluOut)
	);

	// watches the same nets as the DUT
	tbChecker checkUnit (
		.CLK(CLK),
		.rst(rst),
		.inst(inst),
		.memWrite(memWrite),
		.memEn(memEn),
		.memAddr(memAddr),
		.memWdata(memWdata),
		.flags(flags),
		.debugB(debugB),
		.aluOut(aluOut),
		.errors(errors)
	);

	initial CLK = 1'b0;
	always #(HALF_PERIOD) CLK = ~CLK;

	// store marks the upper bits so a load must drop them
	always @(posedge CLK) begin
		if (memEn && memWrite) begin
			mem[memAddr[7:0]] <= {2'b11, memWdata};
		end
	end

	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
			$display("tests failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	// 16-bit fibonacci lfsr, x^16 + x^14 + x^13 + x^11 + 1
	function automatic word_t takeBits(int n);
		word_t v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[14:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic instWord_t encodeReg(opcode_t op, int d, int s);
		return {op, regIdx_t'(d), regIdx_t'(s), 6'b0};
	endfunction

	function automatic instWord_t encodeImm(opcode_t op, int d, logic [7:0] imm8);
		return {op, regIdx_t'(d), imm8, 2'b0};
	endfunction

	task automatic issue(instWord_t i);
		@(negedge CLK);
		inst = i;
		// read data follows the address of the new instruction
		#1;
		memRdata = mem[memAddr[7:0]];
	endtask

	// waits out the flag compare of the last instruction
	task automatic finishTest(string name);
		int found;
		@(posedge CLK);
		#2;
		found = errors - errorsBefore;
		errorsBefore = errors;
		testsRun++;
		if (found == 0) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d mismatches", name, found);
		end
	endtask

	//////////////////////////////////////////////////
	// tests
	//////////////////////////////////////////////////

	initial begin
		int d;
		int s;
		opcode_t op;
		inst = encodeReg(OP_NOP, 0, 0);
		memRdata = '0;
		rst = 1'b1;
		lfsr = 16'd21;
		for (int a = 0; a < MEM_WORDS; a++) begin
			mem[a] = {a[1:0], ~a[7:0], a[7:0]};
		end
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		rst = 1'b0;

		// every register reads back zero
		for (int r = 0; r < NUM_REGS; r++) begin
			issue(encodeReg(OP_MOV, 0, r));
		end
		issue(encodeReg(OP_NOP, 0, 0));
		issue(encodeReg(OP_NOP, 5, 9));
		finishTest("reset");

		issue(encodeImm(OP_MOVI, 1, 8'hF0));
		issue(encodeImm(OP_ADDI, 2, 8'h80));
		issue(encodeImm(OP_SUBI, 3, 8'hFF));
		issue(encodeImm(OP_MOVI, 4, 8'h7F));
		issue(encodeImm(OP_ADDI, 4, 8'hFE));
		issue(encodeImm(OP_SUBI, 4, 8'h90));
		for (int r = 1; r <= 4; r++) begin
			issue(encodeReg(OP_MOV, 0, r));
		end
		finishTest("immediates");

		// seed values reach the upper byte through sign extension
		for (int r = 0; r < NUM_REGS; r++) begin
			issue(encodeImm(OP_MOVI, r, 8'(takeBits(8))));
			issue(encodeImm(OP_ADDI, r, 8'(takeBits(8))));
		end
		for (int n = 0; n < 200; n++) begin
			op = opcode_t'(4'(1 + takeBits(4) % 9));
			d = int'(takeBits(4));
			s = int'(takeBits(4));
			issue(encodeReg(op, d, s));
		end
		for (int r = 0; r < NUM_REGS; r++) begin
			issue(encodeReg(OP_MOV, 0, r));
		end
		finishTest("random register ops");

		// r1 = 0xffff, r2 = 1, r4 = 0x8000
		issue(encodeImm(OP_MOVI, 1, 8'h00));
		issue(encodeImm(OP_SUBI, 1, 8'h01));
		issue(encodeImm(OP_MOVI, 2, 8'h01));
		issue(encodeImm(OP_MOVI, 5, 8'h0F));
		issue(encodeImm(OP_MOVI, 4, 8'h01));
		issue(encodeReg(OP_LSH, 4, 5));
		// signed and unsigned order disagree
		issue(encodeReg(OP_CMP, 1, 2));
		issue(encodeReg(OP_CMP, 2, 1));
		issue(encodeReg(OP_CMP, 2, 2));
		issue(encodeReg(OP_CMP, 4, 2));
		issue(encodeImm(OP_CMPI, 2, 8'hFF));
		issue(encodeImm(OP_CMPI, 4, 8'h00));
		// carry out, then ADDC takes it
		issue(encodeReg(OP_ADD, 1, 2));
		issue(encodeReg(OP_ADDC, 1, 2));
		issue(encodeReg(OP_ADDC, 1, 2));
		// overflow on subtract, add and 0x8000 + 0x8000
		issue(encodeReg(OP_MOV, 3, 4));
		issue(encodeImm(OP_SUBI, 3, 8'h01));
		issue(encodeReg(OP_ADD, 3, 2));
		issue(encodeReg(OP_ADD, 4, 4));
		// flags must hold through these
		issue(encodeReg(OP_AND, 6, 1));
		issue(encodeReg(OP_OR, 6, 2));
		issue(encodeReg(OP_XOR, 6, 6));
		issue(encodeReg(OP_LSH, 2, 5));
		finishTest("flags");

		issue(encodeImm(OP_MOVI, 7, 8'h40));
		issue(encodeImm(OP_MOVI, 8, 8'h5A));
		issue(encodeImm(OP_ADDI, 8, 8'h80));
		issue(encodeImm(OP_MOVI, 9, 8'h41));
		issue(encodeReg(OP_STOR, 8, 7));
		issue(encodeReg(OP_STOR, 7, 9));
		issue(encodeReg(OP_LOAD, 10, 7));
		issue(encodeReg(OP_LOAD, 11, 9));
		// never stored, comes from the fill
		issue(encodeImm(OP_MOVI, 13, 8'h99));
		issue(encodeReg(OP_LOAD, 12, 13));
		issue(encodeReg(OP_CMP, 10, 8));
		for (int r = 10; r <= 12; r++) begin
			issue(encodeReg(OP_MOV, 0, r));
		end
		finishTest("memory");

		$display("%0d tests run, %0d with mismatches, %0d mismatches in total",
			testsRun, testsFailed, errors);
		if (testsFailed == 0 && errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hw/cpuIsaPkg.sv
hw/cpuDataPkg.sv
hw/regPortIf.sv
hw/instDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/datapathCore.sv
testbench/tbChecker.sv
testbench/tbDatapath.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbDatapath
FILELIST = filelist.f
OBJDIR = obj_dir
PASS_MSG = all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
